//--- hdl/core_pkg.sv
package core_pkg;

  localparam int reg_addr_w = 5;
  localparam int xlen = 32;

  // major opcodes, inst[6:0]
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_auipc = 7'b0010111;

  // funct3 of the arithmetic and logic group
  localparam logic [2:0] f3_add = 3'b000;  // add, sub, addi
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_or = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;

  // funct7 of register-register forms
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_sub = 7'b0100000;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor
  } alu_op_e;

  typedef enum logic [1:0] {
    a_rs1,
    a_pc,
    a_zero
  } alu_a_sel_e;

  typedef enum logic {
    b_imm,
    b_rs2
  } alu_b_sel_e;

endpackage

//--- hdl/core_slice.sv
`timescale 1ns/100ps
`default_nettype none

module core_slice (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            inst_valid,
  input  logic [31:0]                     inst,
  input  logic [31:0]                     pc,
  output logic                            inst_ready,
  output logic                            wb_valid,
  input  logic                            wb_ready,
  output logic [core_pkg::reg_addr_w-1:0] wb_rd,
  output logic [core_pkg::xlen-1:0]       wb_data,
  output logic [31:0]                     wb_pc
);

  logic [31:0] dec_inst;
  logic [core_pkg::reg_addr_w-1:0] dec_rs1;
  logic [core_pkg::reg_addr_w-1:0] dec_rs2;
  logic [core_pkg::reg_addr_w-1:0] dec_rd;
  logic [31:0] dec_imm;
  core_pkg::alu_op_e dec_op;
  core_pkg::alu_a_sel_e dec_a_sel;
  core_pkg::alu_b_sel_e dec_b_sel;
  logic dec_uses_rs1;
  logic dec_uses_rs2;

  logic [core_pkg::reg_addr_w-1:0] rs1_addr;
  logic [core_pkg::reg_addr_w-1:0] rs2_addr;
  logic [core_pkg::xlen-1:0] rs1_data;
  logic [core_pkg::xlen-1:0] rs2_data;

  logic [core_pkg::reg_addr_w-1:0] busy_rd;
  logic forward_en;
  logic [core_pkg::xlen-1:0] forward_data;

  logic issue_valid;
  logic exec_ready;
  logic [31:0] issue_pc;
  logic [core_pkg::xlen-1:0] issue_a;
  logic [core_pkg::xlen-1:0] issue_b;
  logic [core_pkg::reg_addr_w-1:0] issue_rd;
  core_pkg::alu_op_e issue_op;

  inst_decoder u_decoder (
    .inst     (dec_inst),
    .rs1_addr (dec_rs1),
    .rs2_addr (dec_rs2),
    .rd_addr  (dec_rd),
    .imm      (dec_imm),
    .alu_op   (dec_op),
    .a_sel    (dec_a_sel),
    .b_sel    (dec_b_sel),
    .uses_rs1 (dec_uses_rs1),
    .uses_rs2 (dec_uses_rs2)
  );

  reg_file u_reg_file (
    .clock  (clock),
    .reset  (reset),
    .we     (forward_en),  // write on writeback transfer
    .waddr  (wb_rd),
    .raddr1 (rs1_addr),
    .raddr2 (rs2_addr),
    .wdata  (wb_data),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

  issue_stage u_issue (
    .clock        (clock),
    .reset        (reset),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .pc           (pc),
    .inst_ready   (inst_ready),
    .dec_inst     (dec_inst),
    .dec_rs1      (dec_rs1),
    .dec_rs2      (dec_rs2),
    .dec_rd       (dec_rd),
    .dec_imm      (dec_imm),
    .dec_op       (dec_op),
    .dec_a_sel    (dec_a_sel),
    .dec_b_sel    (dec_b_sel),
    .dec_uses_rs1 (dec_uses_rs1),
    .dec_uses_rs2 (dec_uses_rs2),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .busy_rd      (busy_rd),
    .forward_en   (forward_en),
    .forward_data (forward_data),
    .issue_valid  (issue_valid),
    .exec_ready   (exec_ready),
    .issue_pc     (issue_pc),
    .issue_a      (issue_a),
    .issue_b      (issue_b),
    .issue_rd     (issue_rd),
    .issue_op     (issue_op)
  );

  exec_unit u_exec (
    .clock        (clock),
    .reset        (reset),
    .issue_valid  (issue_valid),
    .exec_ready   (exec_ready),
    .issue_pc     (issue_pc),
    .issue_a      (issue_a),
    .issue_b      (issue_b),
    .issue_rd     (issue_rd),
    .issue_op     (issue_op),
    .busy_rd      (busy_rd),
    .forward_en   (forward_en),
    .forward_data (forward_data),
    .wb_valid     (wb_valid),
    .wb_ready     (wb_ready),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .wb_pc        (wb_pc)
  );

endmodule

`default_nettype wire

//--- hdl/exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

module exec_unit (
  input  logic                            clock,
  input  logic                            reset,

  input  logic                            issue_valid,
  output logic                            exec_ready,
  input  logic [31:0]                     issue_pc,
  input  logic [core_pkg::xlen-1:0]       issue_a,
  input  logic [core_pkg::xlen-1:0]       issue_b,
  input  logic [core_pkg::reg_addr_w-1:0] issue_rd,
  input  core_pkg::alu_op_e               issue_op,

  output logic [core_pkg::reg_addr_w-1:0] busy_rd,
  output logic                            forward_en,
  output logic [core_pkg::xlen-1:0]       forward_data,

  output logic                            wb_valid,
  input  logic                            wb_ready,
  output logic [core_pkg::reg_addr_w-1:0] wb_rd,
  output logic [core_pkg::xlen-1:0]       wb_data,
  output logic [31:0]                     wb_pc
);

  logic accept;
  logic [core_pkg::xlen-1:0] result;

  assign exec_ready = !wb_valid;  // one entry only
  assign accept = issue_valid && exec_ready;

  always_comb begin
    case (issue_op)
      core_pkg::alu_sub: result = issue_a - issue_b;
      core_pkg::alu_and: result = issue_a & issue_b;
      core_pkg::alu_or:  result = issue_a | issue_b;
      core_pkg::alu_xor: result = issue_a ^ issue_b;
      default:           result = issue_a + issue_b;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else if (accept) begin
      wb_valid <= 1'b1;
    end else if (wb_valid && wb_ready) begin
      wb_valid <= 1'b0;  // empty again after transfer
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      wb_rd <= issue_rd;
      wb_data <= result;
      wb_pc <= issue_pc;
    end
  end

  assign busy_rd = wb_valid ? wb_rd : '0;
  assign forward_en = wb_valid && wb_ready;
  assign forward_data = wb_data;

  wb_hold_a: assert property (@(posedge clock) disable iff (reset)
    wb_valid && !wb_ready |=> wb_valid && $stable({wb_rd, wb_data, wb_pc}))
    else $error("writeback payload changed before it was accepted");

endmodule

`default_nettype wire

//--- hdl/inst_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decoder (
  input  logic [31:0]                     inst,
  output logic [core_pkg::reg_addr_w-1:0] rs1_addr,
  output logic [core_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [core_pkg::reg_addr_w-1:0] rd_addr,
  output logic [31:0]                     imm,
  output core_pkg::alu_op_e               alu_op,
  output core_pkg::alu_a_sel_e            a_sel,
  output core_pkg::alu_b_sel_e            b_sel,
  output logic                            uses_rs1,
  output logic                            uses_rs2
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_u;
  core_pkg::alu_op_e f3_op;
  logic f3_ok;
  logic reg_ok;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign imm_i = {{20{inst[31]}}, inst[31:20]};  // sign extended
  assign imm_u = {inst[31:12], 12'b0};

  always_comb begin
    f3_ok = 1'b1;
    case (funct3)
      core_pkg::f3_add: f3_op = core_pkg::alu_add;
      core_pkg::f3_xor: f3_op = core_pkg::alu_xor;
      core_pkg::f3_or:  f3_op = core_pkg::alu_or;
      core_pkg::f3_and: f3_op = core_pkg::alu_and;
      default: begin
        f3_op = core_pkg::alu_add;
        f3_ok = 1'b0;  // shifts and compares not supported
      end
    endcase
  end

  // only sub may carry the alternate funct7
  assign reg_ok = f3_ok && (funct7 == core_pkg::f7_base ||
                            (funct7 == core_pkg::f7_sub && funct3 == core_pkg::f3_add));

  always_comb begin
    rs1_addr = '0;  // defaults form addi x0, x0, 0
    rs2_addr = '0;
    rd_addr = '0;
    imm = '0;
    alu_op = core_pkg::alu_add;
    a_sel = core_pkg::a_rs1;
    b_sel = core_pkg::b_imm;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (opcode)
      core_pkg::op_reg: begin
        if (reg_ok) begin
          rs1_addr = inst[19:15];
          rs2_addr = inst[24:20];
          rd_addr = inst[11:7];
          alu_op = (funct7 == core_pkg::f7_sub) ? core_pkg::alu_sub : f3_op;
          b_sel = core_pkg::b_rs2;
          uses_rs1 = 1'b1;
          uses_rs2 = 1'b1;
        end
      end
      core_pkg::op_imm: begin
        if (f3_ok) begin
          rs1_addr = inst[19:15];
          rd_addr = inst[11:7];
          imm = imm_i;
          alu_op = f3_op;
          uses_rs1 = 1'b1;
        end
      end
      core_pkg::op_lui: begin
        rd_addr = inst[11:7];
        imm = imm_u;
        a_sel = core_pkg::a_zero;
      end
      core_pkg::op_auipc: begin
        rd_addr = inst[11:7];
        imm = imm_u;
        a_sel = core_pkg::a_pc;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/issue_stage.sv
`timescale 1ns/100ps
`default_nettype none

module issue_stage (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            inst_valid,
  input  logic [31:0]                     inst,
  input  logic [31:0]                     pc,
  output logic                            inst_ready,

  output logic [31:0]                     dec_inst,
  input  logic [core_pkg::reg_addr_w-1:0] dec_rs1,
  input  logic [core_pkg::reg_addr_w-1:0] dec_rs2,
  input  logic [core_pkg::reg_addr_w-1:0] dec_rd,
  input  logic [31:0]                     dec_imm,
  input  core_pkg::alu_op_e               dec_op,
  input  core_pkg::alu_a_sel_e            dec_a_sel,
  input  core_pkg::alu_b_sel_e            dec_b_sel,
  input  logic                            dec_uses_rs1,
  input  logic                            dec_uses_rs2,

  output logic [core_pkg::reg_addr_w-1:0] rs1_addr,
  output logic [core_pkg::reg_addr_w-1:0] rs2_addr,
  input  logic [core_pkg::xlen-1:0]       rs1_data,
  input  logic [core_pkg::xlen-1:0]       rs2_data,

  input  logic [core_pkg::reg_addr_w-1:0] busy_rd,
  input  logic                            forward_en,
  input  logic [core_pkg::xlen-1:0]       forward_data,

  output logic                            issue_valid,
  input  logic                            exec_ready,
  output logic [31:0]                     issue_pc,
  output logic [core_pkg::xlen-1:0]       issue_a,
  output logic [core_pkg::xlen-1:0]       issue_b,
  output logic [core_pkg::reg_addr_w-1:0] issue_rd,
  output core_pkg::alu_op_e               issue_op
);

  typedef enum logic [1:0] {
    st_idle,
    st_wait,
    st_hazard
  } state_e;

  state_e state;
  logic capture;
  logic [1:0] hazard_d;  // bit 0 rs1, bit 1 rs2
  logic [1:0] hazard_q;
  logic [core_pkg::xlen-1:0] op_a;
  logic [core_pkg::xlen-1:0] op_b;

  assign dec_inst = inst;
  assign rs1_addr = dec_rs1;
  assign rs2_addr = dec_rs2;
  assign capture = inst_valid && inst_ready;

  always_comb begin
    case (dec_a_sel)
      core_pkg::a_rs1: op_a = rs1_data;
      core_pkg::a_pc:  op_a = pc;
      default:         op_a = '0;
    endcase
    op_b = (dec_b_sel == core_pkg::b_rs2) ? rs2_data : dec_imm;
  end

  // a forward in this very cycle is already visible through the register file
  always_comb begin
    hazard_d = 2'b00;
    if (busy_rd != '0 && !forward_en) begin
      hazard_d[0] = dec_uses_rs1 && (dec_rs1 == busy_rd);
      hazard_d[1] = dec_uses_rs2 && (dec_rs2 == busy_rd);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
      inst_ready <= 1'b0;
      issue_valid <= 1'b0;
      hazard_q <= 2'b00;
    end else begin
      case (state)
        st_idle: begin
          if (capture) begin
            inst_ready <= 1'b0;
            hazard_q <= hazard_d;
            if (|hazard_d) begin
              state <= st_hazard;
            end else begin
              state <= st_wait;
              issue_valid <= 1'b1;
            end
          end else begin
            inst_ready <= 1'b1;
          end
        end
        st_wait: begin
          if (exec_ready) begin  // accepted by exec
            state <= st_idle;
            issue_valid <= 1'b0;
            inst_ready <= 1'b1;
          end
        end
        st_hazard: begin
          if (forward_en) begin
            state <= st_wait;
            issue_valid <= 1'b1;
          end
        end
        default: begin
          state <= st_idle;
          inst_ready <= 1'b0;
          issue_valid <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (capture) begin
      issue_pc <= pc;
      issue_rd <= dec_rd;
      issue_op <= dec_op;
      issue_a <= op_a;
      issue_b <= op_b;
    end else if (state == st_hazard && forward_en) begin
      if (hazard_q[0]) issue_a <= forward_data;  // patch both if both matched
      if (hazard_q[1]) issue_b <= forward_data;
    end
  end

  issue_hold_a: assert property (@(posedge clock) disable iff (reset)
    issue_valid && !exec_ready |=> issue_valid &&
      $stable({issue_pc, issue_a, issue_b, issue_rd, issue_op}))
    else $error("issue payload changed before exec accepted it");

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            we,
  input  logic [core_pkg::reg_addr_w-1:0] waddr,
  input  logic [core_pkg::reg_addr_w-1:0] raddr1,
  input  logic [core_pkg::reg_addr_w-1:0] raddr2,
  input  logic [core_pkg::xlen-1:0]       wdata,
  output logic [core_pkg::xlen-1:0]       rdata1,
  output logic [core_pkg::xlen-1:0]       rdata2
);

  logic [core_pkg::xlen-1:0] regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin  // x0 never written
      regs[waddr] <= wdata;
    end
  end

  // write-through so a writeback and a same-cycle read agree
  always_comb begin
    if (raddr1 == '0) rdata1 = '0;
    else if (we && waddr == raddr1) rdata1 = wdata;
    else rdata1 = regs[raddr1];
  end

  always_comb begin
    if (raddr2 == '0) rdata2 = '0;
    else if (we && waddr == raddr2) rdata2 = wdata;
    else rdata2 = regs[raddr2];
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build with verilator, run, then decide on the log contents
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
  -f sim.f --top-module core_slice_tb -o core_slice_sim \
  && ./obj_dir/core_slice_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qsx "Testbench passed" sim.log && echo "run ok" || { echo "run not ok"; exit 1; }

//--- sim.f
hdl/core_pkg.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/issue_stage.sv
hdl/exec_unit.sv
hdl/core_slice.sv
verif/clock_gen.sv
verif/core_slice_tb.sv

//--- verif/clock_gen.sv
`timescale 1ns/100ps

module clock_gen #(
  parameter int half_period = 2,
  parameter int reset_cycles = 8
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #half_period clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clock);
    #1 reset = 1'b0;  // released just after the edge, like other inputs
  end

endmodule

//--- verif/core_slice_tb.sv
`timescale 1ns/100ps

module core_slice_tb;

  localparam int n_inst = 440;  // about 400 legal plus some illegal encodings
  localparam int clock_ns = 4;
  localparam int timeout_ns = (n_inst * 20 + 8) * clock_ns;

  logic clock;
  logic reset;
  logic inst_valid;
  logic [31:0] inst;
  logic [31:0] pc;
  logic inst_ready;
  logic wb_valid;
  logic wb_ready;
  logic [core_pkg::reg_addr_w-1:0] wb_rd;
  logic [core_pkg::xlen-1:0] wb_data;
  logic [31:0] wb_pc;

  integer seed = 32'h4d20_62ff;
  int gen_count = 0;
  int wb_count = 0;
  logic [31:0] next_pc = 32'h0000_1000;
  logic [31:0] model_regs [32];
  logic [31:0] exp_rd [$];
  logic [31:0] exp_data [$];
  logic [31:0] exp_pc [$];

  clock_gen #(.half_period(clock_ns / 2), .reset_cycles(8)) u_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  core_slice DUT (
    .clock      (clock),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .pc         (pc),
    .inst_ready (inst_ready),
    .wb_valid   (wb_valid),
    .wb_ready   (wb_ready),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .wb_pc      (wb_pc)
  );

  task automatic stop_run();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
      stop_run();
    end
  endtask

  function automatic int rand_below(input int range);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % range;
  endfunction

  function automatic logic [2:0] funct3_for(input core_pkg::alu_op_e op);
    case (op)
      core_pkg::alu_and: return core_pkg::f3_and;
      core_pkg::alu_or:  return core_pkg::f3_or;
      core_pkg::alu_xor: return core_pkg::f3_xor;
      default:           return core_pkg::f3_add;  // add and sub
    endcase
  endfunction

  // rv32i semantics of the five operations
  function automatic logic [31:0] alu_model(input core_pkg::alu_op_e op,
                                            input logic [31:0] a, input logic [31:0] b);
    case (op)
      core_pkg::alu_sub: return a - b;
      core_pkg::alu_and: return a & b;
      core_pkg::alu_or:  return a | b;
      core_pkg::alu_xor: return a ^ b;
      default:           return a + b;
    endcase
  endfunction

  // assemble one instruction, run it through the model, then offer it
  task automatic offer_next();
    int sel;
    int sub;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [6:0] f7;
    logic [31:0] word;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] result;
    core_pkg::alu_op_e op;
    sel = rand_below(20);
    sub = rand_below(4);
    rd = 5'(rand_below(8));  // x0..x7 keeps hazards frequent
    rs1 = 5'(rand_below(8));
    rs2 = 5'(rand_below(8));
    imm12 = 12'(rand_below(4096));
    imm20 = 20'(rand_below(1 << 20));
    op = core_pkg::alu_add;
    a = model_regs[rs1];
    b = model_regs[rs2];
    if (sel < 7) begin
      op = core_pkg::alu_op_e'(3'(rand_below(5)));
      f7 = (op == core_pkg::alu_sub) ? core_pkg::f7_sub : core_pkg::f7_base;
      word = {f7, rs2, rs1, funct3_for(op), rd, core_pkg::op_reg};
    end else if (sel < 14) begin
      op = (sub == 0) ? core_pkg::alu_add : core_pkg::alu_op_e'(3'(sub + 1));
      word = {imm12, rs1, funct3_for(op), rd, core_pkg::op_imm};
      b = {{20{imm12[11]}}, imm12};
    end else if (sel < 17) begin
      word = {imm20, rd, (sel < 16) ? core_pkg::op_lui : core_pkg::op_auipc};
      a = (sel < 16) ? 32'd0 : next_pc;
      b = {imm20, 12'b0};
    end else begin
      case (sub)
        0: word = {7'b0, rs2, rs1, 3'b001, rd, core_pkg::op_imm};  // slli
        1: word = {core_pkg::f7_base, rs2, rs1, 3'b010, rd, core_pkg::op_reg};  // slt
        2: word = {imm12, rs1, 3'b010, rd, 7'b0000011};  // lw
        default: word = {core_pkg::f7_sub, rs2, rs1, core_pkg::f3_xor, rd, core_pkg::op_reg};
      endcase
      rd = '0;  // no-op writes x0 with zero
      a = '0;
      b = '0;
    end
    result = alu_model(op, a, b);
    if (rd != '0) model_regs[rd] = result;
    exp_rd.push_back({27'b0, rd});
    exp_data.push_back(result);
    exp_pc.push_back(next_pc);
    inst_valid = 1'b1;
    inst = word;
    pc = next_pc;
    next_pc = next_pc + 32'd4;
    gen_count++;
  endtask

  task automatic check_writeback();
    if (exp_pc.size() == 0) begin
      $display("writeback of pc %h arrived with no instruction outstanding", wb_pc);
      stop_run();
    end else begin
      check_value("wb_pc", wb_pc, exp_pc.pop_front());
      check_value("wb_rd", {27'b0, wb_rd}, exp_rd.pop_front());
      check_value("wb_data", wb_data, exp_data.pop_front());
      wb_count++;
    end
  endtask

  initial begin
    #(timeout_ns);
    $display("timeout: writebacks stopped arriving, %0d of %0d received", wb_count, n_inst);
    stop_run();
  end

  initial begin
    bit fetch_xfer;
    bit wb_xfer;
    bit held;
    logic [31:0] held_data;
    logic [31:0] held_pc;
    logic [4:0] held_rd;
    inst_valid = 1'b0;
    inst = '0;
    pc = '0;
    wb_ready = 1'b0;
    held = 1'b0;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    @(negedge reset);
    @(negedge clock);
    check_value("wb_valid", {31'b0, wb_valid}, 32'd0);  // first cycle out of reset
    check_value("inst_ready", {31'b0, inst_ready}, 32'd0);
    while (wb_count < n_inst) begin
      fetch_xfer = inst_valid && inst_ready;  // sampled mid-cycle
      wb_xfer = wb_valid && wb_ready;
      if (held) begin
        check_value("wb_valid", {31'b0, wb_valid}, 32'd1);
        check_value("wb_data", wb_data, held_data);
        check_value("wb_pc", wb_pc, held_pc);
        check_value("wb_rd", {27'b0, wb_rd}, {27'b0, held_rd});
      end
      held = wb_valid && !wb_ready;
      held_data = wb_data;
      held_pc = wb_pc;
      held_rd = wb_rd;
      if (wb_xfer) check_writeback();
      @(posedge clock);
      #1;
      wb_ready = (rand_below(4) != 0);
      if (fetch_xfer || !inst_valid) begin
        if (gen_count < n_inst && rand_below(3) != 0) offer_next();
        else inst_valid = 1'b0;
      end
      @(negedge clock);
    end
    repeat (10) begin  // nothing extra may follow the last result
      @(negedge clock);
      check_value("wb_valid", {31'b0, wb_valid}, 32'd0);
    end
    $display("Testbench passed");
    $finish;
  end

endmodule
